/* flist.f */
logic/rv_isa_pkg.sv
logic/ex_stage_pkg.sv
logic/operand_select.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/mult_unit.sv
logic/completion_arbiter.sv
logic/ex_stage.sv
verification/ex_stage_props.sv
verification/ex_stage_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ex_stage_tb
FILELIST   = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = >>> FAIL
PASS_MSG   = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q -e '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q -e '$(PASS_MSG)' $(LOG); then echo "simulation gave no result"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/ex_stage_tb.sv */
////////////////////////////////////////
// directed testbench for ex_stage
// inputs change on the falling edge and
// outputs are sampled there as well
// one issue port, so contention is built
// from issues in adjacent cycles
////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage_tb
    import rv_isa_pkg::*, ex_stage_pkg::*;
();

    localparam int MULT_STAGES = 4;
    localparam int TIMEOUT     = 20;

    logic             clock = 1'b0;
    logic             reset;
    issue_packet_t    issue;
    complete_packet_t complete;
    logic             free_alu;
    logic             free_mult;
    logic             free_branch;

    logic [31:0]      lfsr_state = 32'd83;
    int               mismatches;
    int               other_errors;

    ex_stage #(
        .MULT_STAGES (MULT_STAGES)
    ) ex_stage_inst (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .complete    (complete),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

    always #50 clock = ~clock;

    ////////////////////////////////////////
    // stimulus source
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'ha300_0000;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] word);
        word = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word       = {word[30:0], lfsr_state[0]};
        end
    endtask

    task automatic new_packet(input fu_kind_t kind, input alu_func_t func,
                              output issue_packet_t p);
        logic [31:0] word;
        p          = '0;
        p.valid    = 1'b1;
        p.fu_kind  = kind;
        p.alu_func = func;
        random_bits(32, word);
        p.inst = word;
        random_bits(30, word);
        p.pc  = {word[29:0], 2'b00};
        p.npc = p.pc + 32'd4;
        random_bits(32, word);
        p.opa_value = word;
        random_bits(32, word);
        p.opb_value = word;
        random_bits(11, word);
        p.tag = word[10:0];
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic logic [XLEN-1:0] operand_a_of(issue_packet_t p);
        case (p.opa_select)
            OPA_IS_NPC:  return p.npc;
            OPA_IS_PC:   return p.pc;
            OPA_IS_ZERO: return '0;
            default:     return p.opa_value;
        endcase
    endfunction

    // immediates rebuilt from the raw instruction bits
    function automatic logic [XLEN-1:0] operand_b_of(issue_packet_t p);
        logic [31:0] w;
        w = p.inst;
        case (p.opb_select)
            OPB_IS_I_IMM: return {{20{w[31]}}, w[31:20]};
            OPB_IS_B_IMM: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPB_IS_J_IMM: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:      return p.opb_value;
        endcase
    endfunction

    function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [XLEN-1:0] alu_reference(alu_func_t func, logic [31:0] a,
                                                      logic [31:0] b);
        logic [63:0] fill;
        fill = {{32{a[31]}}, a} >> b[4:0];
        case (func)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLT:  return {31'b0, signed_less(a, b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return fill[31:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] mult_reference(alu_func_t func, logic [31:0] a,
                                                       logic [31:0] b);
        logic [63:0] wide_a;
        logic [63:0] wide_b;
        logic [63:0] product;
        wide_a  = {{32{a[31] && (func == ALU_MULH || func == ALU_MULHSU)}}, a};
        wide_b  = {{32{b[31] && (func == ALU_MULH)}}, b};
        product = wide_a * wide_b;
        return (func == ALU_MUL) ? product[31:0] : product[63:32];
    endfunction

    // funct3 bit 2 picks a compare, bit 1 unsigned, bit 0 inverts
    function automatic logic branch_taken(issue_packet_t p);
        logic [31:0] w;
        logic        less;
        logic        cond;
        w    = p.inst;
        less = w[13] ? (p.opa_value < p.opb_value) : signed_less(p.opa_value, p.opb_value);
        cond = w[14] ? less : (p.opa_value == p.opb_value);
        cond = cond ^ w[12];
        return p.uncond_branch || (p.cond_branch && cond);
    endfunction

    function automatic fu_result_t predict(issue_packet_t p);
        fu_result_t  r;
        logic [31:0] a;
        logic [31:0] b;
        a             = operand_a_of(p);
        b             = operand_b_of(p);
        r.tag         = p.tag;
        r.take_branch = 1'b0;
        case (p.fu_kind)
            FU_MULT: r.result = mult_reference(p.alu_func, a, b);
            FU_BRANCH: begin
                r.result      = a + b;
                r.take_branch = branch_taken(p);
            end
            default: r.result = alu_reference(p.alu_func, a, b);
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s result: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_take(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s take_branch: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s complete.valid: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_tag(input string name, input result_tag_t got,
                             input result_tag_t exp);
        if (got !== exp) begin
            $display("mismatch %s tag: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // free pulses packed as {branch, mult, alu}
    task automatic check_free(input string name, input logic [2:0] got,
                              input logic [2:0] exp);
        if (got !== exp) begin
            $display("mismatch %s free: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////
    // drive and collect
    ////////////////////////////////////////
    task automatic send(input issue_packet_t p);
        @(negedge clock);
        issue = p;
    endtask

    task automatic wait_complete(output bit seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clock);
            issue.valid = 1'b0;
            cycles++;
            seen = complete.valid;
        end
    endtask

    task automatic collect(input string name, input fu_result_t exp,
                           input logic [2:0] exp_free, input int exp_cycles);
        bit seen;
        int cycles;
        wait_complete(seen, cycles);
        if (!seen) begin
            $display("%s: no completion within %0d cycles", name, TIMEOUT);
            other_errors++;
        end else begin
            if (cycles != exp_cycles) begin
                $display("%s: completion after %0d cycles instead of %0d",
                         name, cycles, exp_cycles);
                other_errors++;
            end
            check_result(name, complete.fu_result.result, exp.result);
            check_take(name, complete.fu_result.take_branch, exp.take_branch);
            check_tag(name, complete.fu_result.tag, exp.tag);
            check_free(name, {free_branch, free_mult, free_alu}, exp_free);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_after_reset();
        for (int k = 0; k < 6; k++) begin
            @(negedge clock);
            check_valid("after reset", complete.valid, 1'b0);
            check_free("idle after reset", {free_branch, free_mult, free_alu}, 3'b000);
        end
    endtask

    task automatic test_alu();
        issue_packet_t p;
        for (int f = 0; f < 10; f++) begin
            for (int v = 0; v < 4; v++) begin
                new_packet(FU_ALU, alu_func_t'(f), p);
                p.opa_select = (v == 2) ? OPA_IS_PC : (v == 3) ? OPA_IS_ZERO : OPA_IS_RS1;
                p.opb_select = v[0] ? OPB_IS_I_IMM : OPB_IS_RS2;
                send(p);
                collect($sformatf("alu %s v%0d", p.alu_func.name(), v), predict(p),
                        3'b001, 2);
            end
        end
    endtask

    task automatic test_branch();
        logic [2:0]    functs [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        issue_packet_t p;
        logic [31:0]   w;
        logic [31:0]   base;
        logic [31:0]   step;
        for (int f = 0; f < 6; f++) begin
            // equal, lower, higher, then signs that differ
            for (int c = 0; c < 4; c++) begin
                new_packet(FU_BRANCH, ALU_ADD, p);
                w            = p.inst;
                w[14:12]     = functs[f];
                p.inst       = w;
                p.opa_select = OPA_IS_PC;
                p.opb_select = OPB_IS_B_IMM;
                p.cond_branch = 1'b1;
                base = p.opa_value >> 2;
                step = (p.opb_value >> 2) + 32'd1;
                case (c)
                    0: p.opb_value = p.opa_value;
                    1: begin
                        p.opa_value = base;
                        p.opb_value = base + step;
                    end
                    2: begin
                        p.opa_value = base + step;
                        p.opb_value = base;
                    end
                    default: begin
                        p.opa_value = p.opa_value | 32'h8000_0000;
                        p.opb_value = base;
                    end
                endcase
                send(p);
                collect($sformatf("branch %b case %0d", functs[f], c), predict(p),
                        3'b100, 2);
            end
        end
        new_packet(FU_BRANCH, ALU_ADD, p);
        p.opa_select    = OPA_IS_PC;
        p.opb_select    = OPB_IS_J_IMM;
        p.uncond_branch = 1'b1;
        send(p);
        collect("jump", predict(p), 3'b100, 2);
    endtask

    task automatic test_multiply();
        issue_packet_t p [4];
        fu_result_t    exp [4];
        for (int k = 0; k < 4; k++) begin
            new_packet(FU_MULT, alu_func_t'(10 + k), p[k]);
            exp[k] = predict(p[k]);
        end
        for (int k = 0; k < 4; k++) begin
            send(p[k]);
        end
        // first result counted from the last issue, then one per cycle
        for (int k = 0; k < 4; k++) begin
            collect($sformatf("mult %s", p[k].alu_func.name()), exp[k], 3'b010,
                    (k == 0) ? MULT_STAGES - 1 : 1);
        end
    endtask

    task automatic test_contention();
        issue_packet_t mul_p;
        issue_packet_t alu_p;
        issue_packet_t br_p;
        issue_packet_t idle_p;
        new_packet(FU_MULT, ALU_MULHU, mul_p);
        new_packet(FU_ALU, ALU_XOR, alu_p);
        new_packet(FU_BRANCH, ALU_ADD, br_p);
        br_p.opa_select    = OPA_IS_PC;
        br_p.opb_select    = OPB_IS_B_IMM;
        br_p.uncond_branch = 1'b1;
        idle_p             = '0;
        send(mul_p);
        for (int k = 1; k < MULT_STAGES; k++) begin
            send(idle_p);
        end
        // alu finishes with the multiply, the branch lands while both wait
        send(alu_p);
        send(br_p);
        collect("contention alu", predict(alu_p), 3'b001, 1);
        collect("contention mult", predict(mul_p), 3'b010, 1);
        collect("contention branch", predict(br_p), 3'b100, 1);
    endtask

    initial begin
        reset        = 1'b1;
        issue        = '0;
        mismatches   = 0;
        other_errors = 0;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        test_after_reset();
        test_alu();
        test_branch();
        test_multiply();
        test_contention();
        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/ex_stage_props.sv */
////////////////////////////////////////
// concurrent checks on the completion
// arbiter; bound into every instance
// and quiet while reset is high
////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage_props
    import ex_stage_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic [2:0] done_in,
    input logic [2:0] full_q,
    input logic [2:0] grant,
    input logic       free_alu,
    input logic       free_mult
);

    // ALU slot has top priority, so it never waits
    alu_freed_in_two: assert property (@(posedge clock) disable iff (reset)
        done_in[FU_ALU] |-> ##2 free_alu)
        else $error("ALU result not released two cycles after its done");

    // ALU slot fills at most every other cycle, so a multiply waits one cycle at most
    mult_freed_in_time: assert property (@(posedge clock) disable iff (reset)
        done_in[FU_MULT] |-> ##[2:3] free_mult)
        else $error("multiply result not released within three cycles of its done");

    // a slot may refill only in the cycle it is released
    no_slot_overwrite: assert property (@(posedge clock) disable iff (reset)
        !(|(done_in & full_q & ~grant)))
        else $error("done arrived at a full hold slot");

endmodule

bind completion_arbiter ex_stage_props ex_stage_props_inst (
    .clock     (clock),
    .reset     (reset),
    .done_in   (done_in),
    .full_q    (full_q),
    .grant     (grant),
    .free_alu  (free_alu),
    .free_mult (free_mult)
);

/* logic/ex_stage.sv */
////////////////////////////////////////
// execute stage, one issue per cycle
// no back-pressure from completion; the
// issuer waits for the free pulses
////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int MULT_STAGES = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  issue_packet_t    issue,
    output complete_packet_t complete,
    output logic             free_alu,
    output logic             free_mult,
    output logic             free_branch
);

    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            alu_done;
    logic            mult_done;
    logic            branch_done;
    fu_result_t      alu_result;
    fu_result_t      mult_result;
    fu_result_t      branch_result;

    operand_select operand_select_inst (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    alu_unit alu_unit_inst (
        .issue  (issue),
        .opa    (opa),
        .opb    (opb),
        .done   (alu_done),
        .result (alu_result)
    );

    branch_unit branch_unit_inst (
        .issue  (issue),
        .opa    (opa),
        .opb    (opb),
        .done   (branch_done),
        .result (branch_result)
    );

    mult_unit #(
        .MULT_STAGES (MULT_STAGES)
    ) mult_unit_inst (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .opa    (opa),
        .opb    (opb),
        .done   (mult_done),
        .result (mult_result)
    );

    completion_arbiter completion_arbiter_inst (
        .clock         (clock),
        .reset         (reset),
        .alu_done      (alu_done),
        .alu_result    (alu_result),
        .mult_done     (mult_done),
        .mult_result   (mult_result),
        .branch_done   (branch_done),
        .branch_result (branch_result),
        .complete      (complete),
        .free_alu      (free_alu),
        .free_mult     (free_mult),
        .free_branch   (free_branch)
    );

endmodule

/* logic/completion_arbiter.sv */
////////////////////////////////////////
// one hold slot per unit, one result out
// per cycle, fixed priority by fu_kind_t
// a done into a full slot overwrites it
////////////////////////////////////////
`timescale 1ns/1ps

module completion_arbiter
    import ex_stage_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             alu_done,
    input  fu_result_t       alu_result,
    input  logic             mult_done,
    input  fu_result_t       mult_result,
    input  logic             branch_done,
    input  fu_result_t       branch_result,
    output complete_packet_t complete,
    output logic             free_alu,
    output logic             free_mult,
    output logic             free_branch
);

    localparam int NUM_UNITS = 3;

    logic [NUM_UNITS-1:0] done_in;
    fu_result_t           result_in [NUM_UNITS];
    logic [NUM_UNITS-1:0] full_q;
    fu_result_t           hold_q [NUM_UNITS];
    logic [NUM_UNITS-1:0] grant;
    logic [NUM_UNITS-1:0] free_q;
    fu_result_t           sel_d;
    fu_result_t           sel_q;

    assign done_in[FU_ALU]      = alu_done;
    assign done_in[FU_MULT]     = mult_done;
    assign done_in[FU_BRANCH]   = branch_done;
    assign result_in[FU_ALU]    = alu_result;
    assign result_in[FU_MULT]   = mult_result;
    assign result_in[FU_BRANCH] = branch_result;

    // lowest full index wins
    assign grant = full_q & (~full_q + 1'b1);

    always_comb begin
        sel_d = '0;
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (grant[k]) begin
                sel_d = hold_q[k];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            full_q <= '0;
            free_q <= '0;
        end else begin
            full_q <= (full_q & ~grant) | done_in;
            free_q <= grant;
        end
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (done_in[k]) begin
                hold_q[k] <= result_in[k];
            end
        end
        sel_q <= sel_d;
    end

    ////////////////////////////////////////
    // outputs, one cycle after the grant
    ////////////////////////////////////////
    assign complete.valid     = |free_q;
    assign complete.fu_result = sel_q;
    assign free_alu           = free_q[FU_ALU];
    assign free_mult          = free_q[FU_MULT];
    assign free_branch        = free_q[FU_BRANCH];

endmodule

/* logic/mult_unit.sv */
////////////////////////////////////////
// pipelined 32x32 multiplier
// MULT_STAGES must divide 64; each stage
// adds one slice of the multiplier
// result comes out MULT_STAGES cycles
// after issue, in issue order
////////////////////////////////////////
`timescale 1ns/1ps

module mult_unit
    import rv_isa_pkg::*, ex_stage_pkg::*;
#(
    parameter int MULT_STAGES = 4
) (
    input  logic            clock,
    input  logic            reset,
    input  issue_packet_t   issue,
    input  logic [XLEN-1:0] opa,
    input  logic [XLEN-1:0] opb,
    output logic            done,
    output fu_result_t      result
);

    // multiplier bits consumed per stage
    localparam int CHUNK = 64 / MULT_STAGES;

    typedef struct packed {
        logic        valid;
        result_tag_t tag;
        alu_func_t   func;
        logic [63:0] product;
        logic [63:0] mcand;
        logic [63:0] mplier;
    } mult_stage_t;

    mult_stage_t stage_in;
    mult_stage_t stage_d [MULT_STAGES];
    mult_stage_t stage_q [MULT_STAGES];
    logic        signed_a;
    logic        signed_b;

    // one shift-and-add step
    function automatic mult_stage_t advance(mult_stage_t s);
        mult_stage_t n;
        n         = s;
        n.product = s.product + s.mcand * 64'(s.mplier[CHUNK-1:0]);
        n.mcand   = s.mcand << CHUNK;
        n.mplier  = s.mplier >> CHUNK;
        return n;
    endfunction

    // low word is the same for any signedness
    assign signed_a = (issue.alu_func == ALU_MULH) || (issue.alu_func == ALU_MULHSU);
    assign signed_b = (issue.alu_func == ALU_MULH);

    always_comb begin
        stage_in.valid   = issue.valid && (issue.fu_kind == FU_MULT);
        stage_in.tag     = issue.tag;
        stage_in.func    = issue.alu_func;
        stage_in.product = '0;
        stage_in.mcand   = {{32{signed_a & opa[XLEN-1]}}, opa};
        stage_in.mplier  = {{32{signed_b & opb[XLEN-1]}}, opb};
    end

    always_comb begin
        stage_d[0] = advance(stage_in);
        for (int k = 1; k < MULT_STAGES; k++) begin
            stage_d[k] = advance(stage_q[k-1]);
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < MULT_STAGES; k++) begin
            stage_q[k] <= stage_d[k];
            if (reset) begin
                stage_q[k].valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // last stage
    ////////////////////////////////////////
    assign done               = stage_q[MULT_STAGES-1].valid;
    assign result.result      = (stage_q[MULT_STAGES-1].func == ALU_MUL) ?
                                stage_q[MULT_STAGES-1].product[31:0] :
                                stage_q[MULT_STAGES-1].product[63:32];
    assign result.take_branch = 1'b0;
    assign result.tag         = stage_q[MULT_STAGES-1].tag;

endmodule

/* logic/branch_unit.sv */
////////////////////////////////////////
// branch target and direction
// condition compares the raw register
// values, not the muxed operands
////////////////////////////////////////
`timescale 1ns/1ps

module branch_unit
    import rv_isa_pkg::*, ex_stage_pkg::*;
(
    input  issue_packet_t   issue,
    input  logic [XLEN-1:0] opa,
    input  logic [XLEN-1:0] opb,
    output logic            done,
    output fu_result_t      result
);

    branch_funct_t funct;
    logic          cond_true;

    assign done  = issue.valid && (issue.fu_kind == FU_BRANCH);
    assign funct = branch_funct_t'(issue.inst.b.funct3);

    always_comb begin
        case (funct)
            BR_EQ:   cond_true = (issue.opa_value == issue.opb_value);
            BR_NE:   cond_true = (issue.opa_value != issue.opb_value);
            BR_LT:   cond_true = ($signed(issue.opa_value) < $signed(issue.opb_value));
            BR_GE:   cond_true = ($signed(issue.opa_value) >= $signed(issue.opb_value));
            BR_LTU:  cond_true = (issue.opa_value < issue.opb_value);
            BR_GEU:  cond_true = (issue.opa_value >= issue.opb_value);
            default: cond_true = 1'b0;
        endcase
    end

    // target is selected base plus offset
    assign result.result      = opa + opb;
    assign result.take_branch = issue.uncond_branch || (issue.cond_branch && cond_true);
    assign result.tag         = issue.tag;

endmodule

/* logic/alu_unit.sv */
////////////////////////////////////////
// single-cycle integer ALU
// multiply codes give zero here, they
// belong to the multiplier
////////////////////////////////////////
`timescale 1ns/1ps

module alu_unit
    import rv_isa_pkg::*, ex_stage_pkg::*;
(
    input  issue_packet_t   issue,
    input  logic [XLEN-1:0] opa,
    input  logic [XLEN-1:0] opb,
    output logic            done,
    output fu_result_t      result
);

    logic [XLEN-1:0] alu_out;

    assign done = issue.valid && (issue.fu_kind == FU_ALU);

    always_comb begin
        case (issue.alu_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_SLT:  alu_out = XLEN'($signed(opa) < $signed(opb));
            ALU_SLTU: alu_out = XLEN'(opa < opb);
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            // shift amount is the low five bits only
            ALU_SLL:  alu_out = opa << opb[4:0];
            ALU_SRL:  alu_out = opa >> opb[4:0];
            ALU_SRA:  alu_out = $unsigned($signed(opa) >>> opb[4:0]);
            default:  alu_out = '0;
        endcase
    end

    assign result.result      = alu_out;
    assign result.take_branch = 1'b0;
    assign result.tag         = issue.tag;

endmodule

/* logic/operand_select.sv */
////////////////////////////////////////
// operand muxes shared by all units
// purely combinational
// unused opb select codes give a marker
////////////////////////////////////////
`timescale 1ns/1ps

module operand_select
    import rv_isa_pkg::*, ex_stage_pkg::*;
(
    input  issue_packet_t   issue,
    output logic [XLEN-1:0] opa,
    output logic [XLEN-1:0] opb
);

    always_comb begin
        case (issue.opa_select)
            OPA_IS_RS1:  opa = issue.opa_value;
            OPA_IS_NPC:  opa = issue.npc;
            OPA_IS_PC:   opa = issue.pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = 32'hdead_face;
        endcase
    end

    // operand B, register or decoded immediate
    always_comb begin
        case (issue.opb_select)
            OPB_IS_RS2:   opb = issue.opb_value;
            OPB_IS_I_IMM: opb = signext_i_imm(issue.inst);
            OPB_IS_S_IMM: opb = signext_s_imm(issue.inst);
            OPB_IS_B_IMM: opb = signext_b_imm(issue.inst);
            OPB_IS_U_IMM: opb = signext_u_imm(issue.inst);
            OPB_IS_J_IMM: opb = signext_j_imm(issue.inst);
            default:      opb = 32'hface_feed;
        endcase
    end

endmodule

/* logic/ex_stage_pkg.sv */
////////////////////////////////////////
// packets between issue, execute and
// complete; one unit of each kind, so
// no functional unit index is carried
////////////////////////////////////////
package ex_stage_pkg;

    import rv_isa_pkg::*;

    localparam int ROB_INDEX_WIDTH = 5;
    localparam int REG_INDEX_WIDTH = 5;

    // also the slot order in the arbiter, ALU highest priority
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MULT,
        FU_BRANCH
    } fu_kind_t;

    // what travels with a result back to the ROB
    typedef struct packed {
        logic                       has_dest;
        logic [REG_INDEX_WIDTH-1:0] dest_reg;
        logic [ROB_INDEX_WIDTH-1:0] rob_index;
    } result_tag_t;

    typedef struct packed {
        logic            valid;
        fu_kind_t        fu_kind;
        inst_t           inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        logic [XLEN-1:0] opa_value;
        logic [XLEN-1:0] opb_value;
        opa_select_t     opa_select;
        opb_select_t     opb_select;
        alu_func_t       alu_func;
        logic            cond_branch;
        logic            uncond_branch;
        result_tag_t     tag;
    } issue_packet_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            take_branch;
        result_tag_t     tag;
    } fu_result_t;

    typedef struct packed {
        logic       valid;
        fu_result_t fu_result;
    } complete_packet_t;

endpackage

/* logic/rv_isa_pkg.sv */
////////////////////////////////////////
// RV32 only: the immediate helpers
// assume a 32-bit XLEN
// alu_func_t codes are internal and are
// not the funct3/funct7 encodings
////////////////////////////////////////
package rv_isa_pkg;

    localparam int XLEN = 32;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_format_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_format_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        s_format_t s;
        b_format_t b;
        u_format_t u;
        j_format_t j;
    } inst_t;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_select_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_select_t;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_funct_t;

    ////////////////////////////////////////
    // sign-extended immediates
    ////////////////////////////////////////
    function automatic logic [XLEN-1:0] signext_i_imm(inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [XLEN-1:0] signext_s_imm(inst_t inst);
        return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

    function automatic logic [XLEN-1:0] signext_b_imm(inst_t inst);
        return {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] signext_u_imm(inst_t inst);
        return {inst.u.imm, 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] signext_j_imm(inst_t inst);
        return {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    endfunction

endpackage
